// ==== tb.f ====
+incdir+tb
hdl/uart_cmd_pkg.sv
hdl/cmd_if.sv
hdl/uart_frame_rx.sv
hdl/cmd_decode.sv
hdl/reg_mem.sv
hdl/reply_tx.sv
hdl/uart_cmd_slave.sv
tb/tb_uart_cmd_slave.sv

// ==== tb/serial_tasks.svh ====
// tasks that send a frame on rx, capture a reply frame from tx and watch tx stay idle

    // start bit, data msb first, xor parity, stop bit
    task automatic send_frame(input uart_cmd_pkg::byte_t data);
        logic [10:0] bits;
        bits = {1'b0, data, ^data, 1'b1};
        @(negedge clk);
        for (int i = 10; i >= 0; i--) begin
            rx = bits[i];
            repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic capture_frame(input int max_wait, output bit found,
                                 output uart_cmd_pkg::byte_t data,
                                 output bit parity, output bit stop);
        int waited;
        found  = 1'b0;
        data   = '0;
        parity = 1'b0;
        stop   = 1'b0;
        waited = 0;
        while (!found && waited < max_wait) begin
            @(negedge clk);
            waited++;
            found = (tx === 1'b0);
        end
        if (found) begin
            repeat (uart_cmd_pkg::CLKS_PER_BIT / 2) @(negedge clk);   // mid start bit
            found = (tx === 1'b0);
            for (int i = 0; i < uart_cmd_pkg::PAYLOAD_BITS; i++) begin
                repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
                data = {data[uart_cmd_pkg::PAYLOAD_BITS-2:0], tx};
            end
            repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
            parity = tx;
            repeat (uart_cmd_pkg::CLKS_PER_BIT) @(negedge clk);
            stop = tx;
        end
    endtask

    task automatic watch_tx_idle(input int cycles, output bit quiet);
        quiet = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            if (tx !== 1'b1) quiet = 1'b0;
        end
    endtask

// ==== tb/tb_uart_cmd_slave.sv ====
// testbench for the serial register-file slave with command table, checks and timeout
`timescale 1ns/1ps

module tb_uart_cmd_slave;

    localparam int B           = uart_cmd_pkg::CLKS_PER_BIT;
    localparam int NUM_CMDS    = 16;
    localparam int TIMEOUT_CYC = NUM_CMDS * 3 * 11 * B + 200;

    typedef struct {
        uart_cmd_pkg::opcode_e op;
        uart_cmd_pkg::addr_t   addr;
        uart_cmd_pkg::byte_t   wdata;
        uart_cmd_pkg::byte_t   exp;
    } cmd_entry_t;

    logic                clk;
    logic                rst_n;
    logic                rx;
    logic                tx;
    cmd_entry_t          cmds [NUM_CMDS];
    uart_cmd_pkg::byte_t ref_mem [uart_cmd_pkg::MEM_DEPTH];
    int                  cycle_cnt;
    int                  pass_cnt;
    int                  fail_cnt;

    uart_cmd_slave dut (.*);

    `include "serial_tasks.svh"

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout, no end of tests after %0d cycles", cycle_cnt);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic set_entry(input int idx, input uart_cmd_pkg::opcode_e op,
                             input int addr, input int wdata);
        cmds[idx].op    = op;
        cmds[idx].addr  = uart_cmd_pkg::addr_t'(addr);
        cmds[idx].wdata = uart_cmd_pkg::byte_t'(wdata);
        cmds[idx].exp   = '0;
    endtask

    task automatic fill_table();
        int a1;
        int a2;
        int a3;
        a1 = $urandom_range(1, 42);     // three disjoint ranges
        a2 = $urandom_range(43, 84);
        a3 = $urandom_range(85, 126);
        set_entry(0, uart_cmd_pkg::OP_WRITE, 'h05, 'h3c);
        set_entry(1, uart_cmd_pkg::OP_READ, 'h05, 0);
        set_entry(2, uart_cmd_pkg::OP_WRITE, 'h00, $urandom);
        set_entry(3, uart_cmd_pkg::OP_WRITE, 'h7f, $urandom);
        set_entry(4, uart_cmd_pkg::OP_WRITE, a1, $urandom);
        set_entry(5, uart_cmd_pkg::OP_WRITE, a2, $urandom);
        set_entry(6, uart_cmd_pkg::OP_WRITE, a3, $urandom);
        set_entry(7, uart_cmd_pkg::OP_READ, 'h00, 0);
        set_entry(8, uart_cmd_pkg::OP_READ, 'h7f, 0);
        set_entry(9, uart_cmd_pkg::OP_READ, a1, 0);
        set_entry(10, uart_cmd_pkg::OP_READ, a2, 0);
        set_entry(11, uart_cmd_pkg::OP_READ, a3, 0);
        set_entry(12, uart_cmd_pkg::OP_WRITE, 'h2a, 'h11);
        set_entry(13, uart_cmd_pkg::OP_WRITE, 'h2a, 'hee);   // overwrite
        set_entry(14, uart_cmd_pkg::OP_READ, 'h2a, 0);
        set_entry(15, uart_cmd_pkg::OP_READ, 'h05, 0);
        // expected read values follow the write history
        for (int i = 0; i < NUM_CMDS; i++) begin
            if (cmds[i].op == uart_cmd_pkg::OP_WRITE) begin
                ref_mem[cmds[i].addr] = cmds[i].wdata;
            end else begin
                cmds[i].exp = ref_mem[cmds[i].addr];
            end
        end
    endtask

    task automatic report(input string what, input bit ok);
        if (ok) pass_cnt++;
        else fail_cnt++;
        $display("test %s %s", what, ok ? "ok" : "failed");
    endtask

    task automatic run_write(input int idx);
        bit quiet;
        fork
            begin
                send_frame({1'b1, cmds[idx].addr});
                send_frame(cmds[idx].wdata);
            end
            watch_tx_idle(24 * B + 2, quiet);   // both frames plus 2 bit times
        join
        if (!quiet) $display("tx went low during a write command, no reply expected");
        report($sformatf("%0d write 0x%02h <- 0x%02h", idx, cmds[idx].addr,
                         cmds[idx].wdata), quiet);
    endtask

    task automatic run_read(input int idx);
        bit                  found;
        bit                  parity;
        bit                  stop;
        bit                  ok;
        uart_cmd_pkg::byte_t data;
        fork
            send_frame({1'b0, cmds[idx].addr});
            capture_frame(13 * B + 2, found, data, parity, stop);  // frame plus 2 bit times
        join
        ok = found;
        if (!found) begin
            $display("no reply frame on tx for read of address 0x%02h", cmds[idx].addr);
        end else begin
            if (data !== cmds[idx].exp) begin
                $display("FAILED tx data: got 0x%02h expected 0x%02h", data, cmds[idx].exp);
                ok = 1'b0;
            end
            if (parity !== ^data) begin
                $display("FAILED tx parity: got 0x%01h expected 0x%01h", parity, ^data);
                ok = 1'b0;
            end
            if (stop !== 1'b1) begin
                $display("FAILED tx stop: got 0x%01h expected 0x1", stop);
                ok = 1'b0;
            end
        end
        report($sformatf("%0d read 0x%02h -> 0x%02h", idx, cmds[idx].addr,
                         cmds[idx].exp), ok);
    endtask

    initial begin
        int seed;
        bit idle_ok;
        seed      = 73;
        void'($urandom(seed));
        rst_n     = 1'b0;
        rx        = 1'b1;
        cycle_cnt = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        idle_ok   = 1'b1;
        fill_table();
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            if (i == 7) rst_n = 1'b1;     // 8 cycles of reset
            if (tx !== 1'b1) begin
                $display("FAILED tx: got 0x%01h expected 0x1", tx);
                idle_ok = 1'b0;
            end
        end
        report("reset tx idle", idle_ok);
        for (int i = 0; i < NUM_CMDS; i++) begin
            if (cmds[i].op == uart_cmd_pkg::OP_WRITE) run_write(i);
            else run_read(i);
        end
        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/uart_cmd_slave.sv ====
// top level of the serial register-file slave
`timescale 1ns/1ps

module uart_cmd_slave (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx
);

    logic                byte_valid;
    uart_cmd_pkg::byte_t rx_byte;
    logic                rd_valid;
    uart_cmd_pkg::byte_t rd_data;

    cmd_if cmd_bus ();

    uart_frame_rx u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    cmd_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .cmd        (cmd_bus.source)
    );

    reg_mem u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd_bus.sink),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    reply_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .tx       (tx)
    );

endmodule

// ==== hdl/reply_tx.sv ====
// reply serializer, sends one read result as a single frame
`timescale 1ns/1ps

module reply_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_valid,
    input  uart_cmd_pkg::byte_t rd_data,
    output logic                tx
);

    localparam int CW  = uart_cmd_pkg::CLK_CNT_BITS;
    localparam int BW  = uart_cmd_pkg::BIT_CNT_BITS;
    localparam int MSB = uart_cmd_pkg::PAYLOAD_BITS - 1;

    uart_cmd_pkg::tx_state_e state;
    logic [CW-1:0]           clk_cnt;
    logic [BW-1:0]           bit_cnt;
    logic                    bit_end;
    uart_cmd_pkg::byte_t     tx_shift;
    logic                    tx_parity;

    assign bit_end = clk_cnt == CW'(uart_cmd_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_cmd_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                uart_cmd_pkg::TX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (rd_valid) begin
                        tx    <= 1'b0;     // start bit
                        state <= uart_cmd_pkg::TX_START;
                    end
                end
                uart_cmd_pkg::TX_START: begin
                    if (bit_end) begin
                        tx    <= tx_shift[MSB];
                        state <= uart_cmd_pkg::TX_DATA;
                    end
                end
                uart_cmd_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BW'(MSB)) begin
                            tx    <= tx_parity;
                            state <= uart_cmd_pkg::TX_PARITY;
                        end else begin
                            tx <= tx_shift[MSB];
                        end
                    end
                end
                uart_cmd_pkg::TX_PARITY: begin
                    if (bit_end) begin
                        tx    <= 1'b1;     // stop bit
                        state <= uart_cmd_pkg::TX_STOP;
                    end
                end
                uart_cmd_pkg::TX_STOP: begin
                    if (bit_end) begin
                        state <= uart_cmd_pkg::TX_IDLE;
                    end
                end
                default: state <= uart_cmd_pkg::TX_IDLE;
            endcase
        end
    end

    // shift out msb first, parity taken before shifting starts
    always_ff @(posedge clk) begin
        if (state == uart_cmd_pkg::TX_IDLE && rd_valid) begin
            tx_shift  <= rd_data;
            tx_parity <= ^rd_data;
        end else if (bit_end && (state == uart_cmd_pkg::TX_START ||
                                 state == uart_cmd_pkg::TX_DATA)) begin
            tx_shift <= {tx_shift[MSB-1:0], 1'b0};
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == uart_cmd_pkg::TX_IDLE |-> tx
    );

    // no back-pressure, a read result must never land mid-frame
    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid |-> state == uart_cmd_pkg::TX_IDLE
    );

endmodule

// ==== hdl/reg_mem.sv ====
// 128 x 8 register memory executing read and write commands
`timescale 1ns/1ps

module reg_mem (
    input  logic                clk,
    input  logic                rst_n,
    cmd_if.sink                 cmd,
    output logic                rd_valid,
    output uart_cmd_pkg::byte_t rd_data
);

    uart_cmd_pkg::byte_t mem [uart_cmd_pkg::MEM_DEPTH];
    logic                do_write;
    logic                do_read;

    assign do_write = cmd.cmd_valid && cmd.cmd_op == uart_cmd_pkg::OP_WRITE;
    assign do_read  = cmd.cmd_valid && cmd.cmd_op == uart_cmd_pkg::OP_READ;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[cmd.cmd_addr] <= cmd.cmd_data;
        end
    end

    // held until the next read
    always_ff @(posedge clk) begin
        if (do_read) begin
            rd_data <= mem[cmd.cmd_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= do_read;
        end
    end

endmodule

// ==== hdl/cmd_decode.sv ====
// command assembler, turns received bytes into read and write commands
`timescale 1ns/1ps

module cmd_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                byte_valid,
    input  uart_cmd_pkg::byte_t rx_byte,
    cmd_if.source               cmd
);

    logic                data_pending;   // write header seen, waiting for data
    uart_cmd_pkg::addr_t wr_addr;
    logic                is_write;

    assign is_write = rx_byte[uart_cmd_pkg::PAYLOAD_BITS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_pending  <= 1'b0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            cmd.cmd_valid <= 1'b0;
            if (byte_valid) begin
                if (data_pending) begin
                    data_pending  <= 1'b0;
                    cmd.cmd_valid <= 1'b1;
                end else if (is_write) begin
                    data_pending <= 1'b1;
                end else begin
                    cmd.cmd_valid <= 1'b1;     // read is a single frame
                end
            end
        end
    end

    // payload fields, qualified by cmd_valid
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            if (data_pending) begin
                cmd.cmd_op   <= uart_cmd_pkg::OP_WRITE;
                cmd.cmd_addr <= wr_addr;
                cmd.cmd_data <= rx_byte;
            end else if (is_write) begin
                wr_addr <= rx_byte[uart_cmd_pkg::ADDR_BITS-1:0];
            end else begin
                cmd.cmd_op   <= uart_cmd_pkg::OP_READ;
                cmd.cmd_addr <= rx_byte[uart_cmd_pkg::ADDR_BITS-1:0];
            end
        end
    end

    a_no_read_mid_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cmd.cmd_valid && cmd.cmd_op == uart_cmd_pkg::OP_READ) |-> !data_pending
    );

endmodule

// ==== hdl/uart_frame_rx.sv ====
// serial frame receiver with mid-bit sampling, one byte out per frame
`timescale 1ns/1ps

module uart_frame_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx,
    output logic                byte_valid,
    output uart_cmd_pkg::byte_t rx_byte
);

    localparam int CW = uart_cmd_pkg::CLK_CNT_BITS;
    localparam int BW = uart_cmd_pkg::BIT_CNT_BITS;

    uart_cmd_pkg::rx_state_e state;
    logic [CW-1:0]           clk_cnt;
    logic [BW-1:0]           bit_cnt;
    logic                    half_tick;
    logic                    bit_tick;

    assign half_tick = clk_cnt == CW'(uart_cmd_pkg::CLKS_PER_BIT / 2 - 1);
    assign bit_tick  = clk_cnt == CW'(uart_cmd_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= uart_cmd_pkg::RX_IDLE;
            clk_cnt    <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                uart_cmd_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rx) begin
                        state <= uart_cmd_pkg::RX_START;
                    end
                end
                uart_cmd_pkg::RX_START: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (half_tick) begin
                        clk_cnt <= '0;
                        // glitch shorter than half a bit goes back to idle
                        state   <= rx ? uart_cmd_pkg::RX_IDLE : uart_cmd_pkg::RX_DATA;
                    end
                end
                uart_cmd_pkg::RX_DATA: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BW'(uart_cmd_pkg::PAYLOAD_BITS - 1)) begin
                            state <= uart_cmd_pkg::RX_PARITY;
                        end
                    end
                end
                uart_cmd_pkg::RX_PARITY: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_tick) begin     // parity not checked
                        clk_cnt <= '0;
                        state   <= uart_cmd_pkg::RX_STOP;
                    end
                end
                uart_cmd_pkg::RX_STOP: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_tick) begin
                        clk_cnt    <= '0;
                        byte_valid <= 1'b1;
                        state      <= uart_cmd_pkg::RX_IDLE;
                    end
                end
                default: state <= uart_cmd_pkg::RX_IDLE;
            endcase
        end
    end

    // msb first, so shift in from the bottom
    always_ff @(posedge clk) begin
        if (state == uart_cmd_pkg::RX_DATA && bit_tick) begin
            rx_byte <= {rx_byte[uart_cmd_pkg::PAYLOAD_BITS-2:0], rx};
        end
    end

    a_byte_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        byte_valid |=> !byte_valid
    );

endmodule

// ==== hdl/cmd_if.sv ====
// command interface between the command assembler and the register memory
`timescale 1ns/1ps

interface cmd_if;

    logic                  cmd_valid;   // one-cycle pulse
    uart_cmd_pkg::opcode_e cmd_op;
    uart_cmd_pkg::addr_t   cmd_addr;
    uart_cmd_pkg::byte_t   cmd_data;    // only meaningful for writes

    modport source (
        output cmd_valid, cmd_op, cmd_addr, cmd_data
    );

    modport sink (
        input cmd_valid, cmd_op, cmd_addr, cmd_data
    );

endinterface

// ==== hdl/uart_cmd_pkg.sv ====
// serial line constants, byte and address types, opcode and FSM state enums
package uart_cmd_pkg;

    localparam int CLK_FREQ     = 50_000_000;
    localparam int BAUD_RATE    = 3_125_000;
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;    // 16
    localparam int PAYLOAD_BITS = 8;
    localparam int ADDR_BITS    = 7;
    localparam int MEM_DEPTH    = 1 << ADDR_BITS;

    // counter widths for the bit timers
    localparam int CLK_CNT_BITS = $clog2(CLKS_PER_BIT);
    localparam int BIT_CNT_BITS = $clog2(PAYLOAD_BITS);

    typedef logic [PAYLOAD_BITS-1:0] byte_t;
    typedef logic [ADDR_BITS-1:0]    addr_t;

    // bit 7 of the first command frame
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } opcode_e;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_e;

endpackage
